// File: Makefile
# Verilator build and run of the clk_synth_config testbench

VERILATOR ?= verilator
TOP       ?= tb_clk_synth_config
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) design/synth_macros.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS SIM_ARGS"

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/clk_synth_config.sv
`timescale 1ns/100ps

module clk_synth_config (
    input  logic                   slow_clk,
    input  logic                   resetS,

    // write port
    input  synth_bus_pkg::bus_wr_t wr,
    input  logic                   wr_valid,
    output logic                   wr_ready,

    // synthesizer serial interface
    output logic                   dclk,
    output logic                   ddat,
    output logic                   dlen,
    output logic                   sync,

    output logic                   busy
);

    logic                        start;
    synth_prog_pkg::word_index_t rd_index;
    synth_prog_pkg::synth_word_t rd_word;
    synth_prog_pkg::shift_req_t  req;
    logic                        req_valid;
    logic                        req_ready;

    // synthesizer samples ddat mid-bit
    assign dclk = ~slow_clk;

    synth_cfg_regs u_cfg_regs (
        .slow_clk (slow_clk),
        .resetS   (resetS),
        .wr       (wr),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .busy     (busy),
        .rd_index (rd_index),
        .rd_word  (rd_word),
        .start    (start)
    );

    synth_prog_sequencer u_sequencer (
        .slow_clk  (slow_clk),
        .resetS    (resetS),
        .start     (start),
        .busy      (busy),
        .rd_index  (rd_index),
        .rd_word   (rd_word),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .sync      (sync)
    );

    synth_serial_shifter u_shifter (
        .slow_clk  (slow_clk),
        .resetS    (resetS),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .ddat      (ddat),
        .dlen      (dlen)
    );

endmodule

// File: design/synth_bus_pkg.sv
`include "synth_macros.svh"

package synth_bus_pkg;

    // one write on the bus side
    // addr 0..25 selects a shadow word, addr 26 is the control register
    typedef struct packed {
        logic [`SYNTH_ADDR_W-1:0] addr;
        logic [`SYNTH_WORD_W-1:0] data;
    } bus_wr_t;

endpackage

// File: design/synth_cfg_regs.sv
`timescale 1ns/100ps
`include "synth_macros.svh"

module synth_cfg_regs (
    input  logic                        slow_clk,
    input  logic                        resetS,

    // write port
    input  synth_bus_pkg::bus_wr_t      wr,
    input  logic                        wr_valid,
    output logic                        wr_ready,

    // sequencer side
    input  logic                        busy,
    input  synth_prog_pkg::word_index_t rd_index,
    output synth_prog_pkg::synth_word_t rd_word,
    output logic                        start
);

    localparam logic [`SYNTH_ADDR_W-1:0] CTRL_ADDR = `SYNTH_ADDR_W'(`SYNTH_CTRL_ADDR);
    localparam logic [`SYNTH_ADDR_W-1:0] NUM_WORDS = `SYNTH_ADDR_W'(`SYNTH_NUM_WORDS);

    synth_prog_pkg::synth_word_t bank [`SYNTH_NUM_WORDS];   // shadow words

    logic wr_fire;
    logic word_sel;
    logic ctrl_sel;

    // ================================================
    // handshake and address decode
    // ================================================
    // no writes while a sequence runs, so the bank is stable during a transfer
    assign wr_ready = ~busy;
    assign wr_fire  = wr_valid & wr_ready;

    assign word_sel = wr.addr < NUM_WORDS;
    assign ctrl_sel = wr.addr == CTRL_ADDR;

    // ================================================
    // word bank
    // ================================================
    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            for (int i = 0; i < `SYNTH_NUM_WORDS; i++) begin
                bank[i] <= synth_prog_pkg::DEFAULT_WORDS[i];
            end
        end else if (wr_fire && word_sel) begin
            bank[wr.addr] <= wr.data;
        end
        // other addresses accepted and dropped
    end

    // ================================================
    // control strobe
    // ================================================
    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            start <= 1'b0;
        end else begin
            start <= wr_fire & ctrl_sel & wr.data[0];   // one cycle pulse
        end
    end

    // sequencer only walks 0..25, out of range reads give zero
    always_comb begin
        if (rd_index < NUM_WORDS) begin
            rd_word = bank[rd_index];
        end else begin
            rd_word = '0;
        end
    end

endmodule

// File: design/synth_macros.svh
`ifndef SYNTH_MACROS_SVH
`define SYNTH_MACROS_SVH

// ================================================
// synthesizer word bank
// ================================================
`define SYNTH_WORD_W    32   // bits per serial word
`define SYNTH_NUM_WORDS 26   // words sent per sequence

// ================================================
// write bus
// ================================================
`define SYNTH_ADDR_W    5
`define SYNTH_CTRL_ADDR 26   // bit 0 of data starts a sequence

// ================================================
// sync pulse after the last word
// ================================================
// low phase, in slow_clk cycles
`define SYNTH_SYNC_LOW_CYCLES  16
// settle time after sync returns high, before busy drops
`define SYNTH_SYNC_HIGH_CYCLES 16

`endif

// File: design/synth_prog_pkg.sv
`include "synth_macros.svh"

package synth_prog_pkg;

    typedef logic [`SYNTH_WORD_W-1:0] synth_word_t;
    typedef logic [$clog2(`SYNTH_NUM_WORDS)-1:0] word_index_t;

    // one word handed from sequencer to shifter
    typedef struct packed {
        synth_word_t word;
        logic        last;   // set on the final word of a sequence
    } shift_req_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_FETCH,       // register the bank word
        SEQ_SEND,        // offer it to the shifter
        SEQ_WAIT,        // shifter busy
        SEQ_SYNC_LOW,
        SEQ_SYNC_HIGH
    } seq_state_t;

    // ================================================
    // power-on contents of the word bank
    // ================================================
    // programming order R0 (with reset bit), R0, R1..R16, R24..R31
    // low 5 bits of every word hold the register address
    localparam synth_word_t DEFAULT_WORDS [`SYNTH_NUM_WORDS] = '{
        32'h0002_0140, 32'h0000_0140,                             // R0 init, R0
        32'h0014_0141, 32'h0014_0142, 32'h8014_0143, 32'h0014_0144,
        32'h0014_0145, 32'h1111_1106, 32'h1111_1107, 32'h1111_1108,
        32'h5555_5549, 32'h9102_410A, 32'h0401_100B, 32'h1B0C_006C,
        32'h3B00_802D, 32'h0000_000E, 32'h8000_800F, 32'hC155_0410, // R1..R16
        32'h0000_0058, 32'h0300_0C19, 32'h8FA8_001A, 32'h0800_001B,
        32'h0020_001C, 32'h0180_033D, 32'h0200_033E, 32'h0000_001F  // R24..R31
    };

endpackage

// File: design/synth_prog_sequencer.sv
`timescale 1ns/100ps
`include "synth_macros.svh"

module synth_prog_sequencer (
    input  logic                        slow_clk,
    input  logic                        resetS,
    input  logic                        start,
    output logic                        busy,

    // word bank read port
    output synth_prog_pkg::word_index_t rd_index,
    input  synth_prog_pkg::synth_word_t rd_word,

    // to the shifter
    output synth_prog_pkg::shift_req_t  req,
    output logic                        req_valid,
    input  logic                        req_ready,

    output logic                        sync
);

    localparam synth_prog_pkg::word_index_t LAST_INDEX =
        $bits(synth_prog_pkg::word_index_t)'(`SYNTH_NUM_WORDS - 1);
    localparam logic [4:0] SYNC_LOW_END  = 5'(`SYNTH_SYNC_LOW_CYCLES - 1);
    localparam logic [4:0] SYNC_HIGH_END = 5'(`SYNTH_SYNC_HIGH_CYCLES - 1);

    synth_prog_pkg::seq_state_t state;
    logic                       auto_start;   // one-shot run after reset
    logic [4:0]                 sync_cnt;

    // ================================================
    // sequence FSM
    // ================================================
    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            state      <= synth_prog_pkg::SEQ_IDLE;
            auto_start <= 1'b1;
            rd_index   <= '0;
            req_valid  <= 1'b0;
            sync_cnt   <= '0;
        end else begin
            case (state)
                synth_prog_pkg::SEQ_IDLE: begin
                    if (start || auto_start) begin
                        auto_start <= 1'b0;
                        rd_index   <= '0;
                        state      <= synth_prog_pkg::SEQ_FETCH;
                    end
                end
                synth_prog_pkg::SEQ_FETCH: begin
                    req_valid <= 1'b1;   // word registered below
                    state     <= synth_prog_pkg::SEQ_SEND;
                end
                synth_prog_pkg::SEQ_SEND: begin
                    if (req_ready) begin
                        req_valid <= 1'b0;
                        state     <= synth_prog_pkg::SEQ_WAIT;
                    end
                end
                synth_prog_pkg::SEQ_WAIT: begin
                    // ready comes back one cycle after dlen rises
                    if (req_ready) begin
                        if (req.last) begin
                            sync_cnt <= '0;
                            state    <= synth_prog_pkg::SEQ_SYNC_LOW;
                        end else begin
                            rd_index <= rd_index + 1'b1;
                            state    <= synth_prog_pkg::SEQ_FETCH;
                        end
                    end
                end
                synth_prog_pkg::SEQ_SYNC_LOW: begin
                    if (sync_cnt == SYNC_LOW_END) begin
                        sync_cnt <= '0;
                        state    <= synth_prog_pkg::SEQ_SYNC_HIGH;
                    end else begin
                        sync_cnt <= sync_cnt + 1'b1;
                    end
                end
                synth_prog_pkg::SEQ_SYNC_HIGH: begin
                    if (sync_cnt == SYNC_HIGH_END) begin
                        state <= synth_prog_pkg::SEQ_IDLE;
                    end else begin
                        sync_cnt <= sync_cnt + 1'b1;
                    end
                end
                default: state <= synth_prog_pkg::SEQ_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge slow_clk) begin
        if (state == synth_prog_pkg::SEQ_FETCH) begin
            req.word <= rd_word;
            req.last <= rd_index == LAST_INDEX;
        end
    end

    // high through reset too, the auto run follows right away
    assign busy = (state != synth_prog_pkg::SEQ_IDLE) | auto_start;
    assign sync = state != synth_prog_pkg::SEQ_SYNC_LOW;

endmodule

// File: design/synth_serial_shifter.sv
`timescale 1ns/100ps
`include "synth_macros.svh"

module synth_serial_shifter (
    input  logic                       slow_clk,
    input  logic                       resetS,
    input  synth_prog_pkg::shift_req_t req,
    input  logic                       req_valid,
    output logic                       req_ready,
    output logic                       ddat,
    output logic                       dlen
);

    localparam logic [4:0] LAST_BIT = 5'(`SYNTH_WORD_W - 1);

    logic [`SYNTH_WORD_W-1:0] sreg;
    logic [4:0]               bit_cnt;
    logic                     shifting;   // dlen low phase
    logic                     tail;       // one cycle after dlen rises

    assign req_ready = ~shifting & ~tail;

    // ================================================
    // control
    // ================================================
    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            shifting <= 1'b0;
            tail     <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            tail <= 1'b0;
            if (req_valid && req_ready) begin
                shifting <= 1'b1;
                bit_cnt  <= '0;
            end else if (shifting) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT) begin
                    shifting <= 1'b0;   // 32 bits out
                    tail     <= 1'b1;
                end
            end
        end
    end

    // ================================================
    // data path, MSB first
    // ================================================
    always_ff @(posedge slow_clk) begin
        if (req_valid && req_ready) begin
            sreg <= req.word;
        end else if (shifting) begin
            sreg <= {sreg[`SYNTH_WORD_W-2:0], 1'b0};
        end
    end

    assign ddat = shifting & sreg[`SYNTH_WORD_W-1];   // quiet low between words
    assign dlen = ~shifting;

endmodule

// File: src.f
+incdir+design
design/synth_bus_pkg.sv
design/synth_prog_pkg.sv
design/synth_cfg_regs.sv
design/synth_prog_sequencer.sv
design/synth_serial_shifter.sv
design/clk_synth_config.sv
test/clk_synth_config_props.sv
test/tb_clk_synth_config.sv

// File: test/clk_synth_config_props.sv
`timescale 1ns/100ps
`include "synth_macros.svh"

module clk_synth_config_props (
    input logic slow_clk,
    input logic resetS,
    input logic wr_ready,
    input logic busy,
    input logic dlen,
    input logic sync
);

    int         fail_count = 0;
    logic [5:0] dlen_low_len;   // low cycles seen so far
    logic [5:0] sync_low_len;

    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            dlen_low_len <= '0;
            sync_low_len <= '0;
        end else begin
            dlen_low_len <= dlen ? 6'd0 : dlen_low_len + 6'd1;
            sync_low_len <= sync ? 6'd0 : sync_low_len + 6'd1;
        end
    end

    // ================================================
    // serial frame and sync pulse lengths
    // ================================================
    dlen_frame_len: assert property (@(posedge slow_clk) disable iff (resetS)
        $rose(dlen) |-> dlen_low_len == 6'(`SYNTH_WORD_W))
        else begin
            $error("dlen low period is not 32 cycles long");
            fail_count++;
        end

    sync_pulse_len: assert property (@(posedge slow_clk) disable iff (resetS)
        $rose(sync) |-> sync_low_len == 6'(`SYNTH_SYNC_LOW_CYCLES))
        else begin
            $error("sync low pulse has the wrong length");
            fail_count++;
        end

    // no write accepted while a sequence or a frame is active
    ready_while_busy: assert property (@(posedge slow_clk) disable iff (resetS)
        !(wr_ready && (busy || !dlen || !sync)))
        else begin
            $error("wr_ready high during a sequence");
            fail_count++;
        end

endmodule

bind clk_synth_config clk_synth_config_props u_props (
    .slow_clk (slow_clk),
    .resetS   (resetS),
    .wr_ready (wr_ready),
    .busy     (busy),
    .dlen     (dlen),
    .sync     (sync)
);

// File: test/tb_clk_synth_config.sv
`timescale 1ns/100ps
`include "synth_macros.svh"

module tb_clk_synth_config;

    localparam int NUM_WORDS     = `SYNTH_NUM_WORDS;
    localparam int RESET_CYCLES  = 8;
    localparam int START_TIMEOUT = 20;
    localparam int SEQ_TIMEOUT   = 2000;   // one sequence is about 1000 cycles
    localparam int FRAME_TIMEOUT = 400;
    localparam int QUIET_CYCLES  = 64;
    localparam logic [`SYNTH_ADDR_W-1:0] CTRL = `SYNTH_ADDR_W'(`SYNTH_CTRL_ADDR);

    typedef enum logic [2:0] {
        OP_AUTO,         // reset, then the auto-start run
        OP_WRITE,        // plain word write
        OP_START,        // control write with bit 0 set
        OP_NO_RUN,       // accepted write that must start nothing
        OP_LATE_WRITE,   // start, then this write held off by busy
        OP_RESET_MID     // start, then reset part way through
    } op_t;

    typedef struct packed {
        logic [3:0]               test_id;
        op_t                      op;
        logic [`SYNTH_ADDR_W-1:0] addr;
        logic [`SYNTH_WORD_W-1:0] data;
        logic                     runs;   // a sequence follows the entry
    } stim_t;

    logic                   slow_clk;
    logic                   resetS;
    synth_bus_pkg::bus_wr_t wr;
    logic                   wr_valid;
    logic                   wr_ready;
    logic                   dclk;
    logic                   ddat;
    logic                   dlen;
    logic                   sync;
    logic                   busy;

    stim_t       table_q [$];
    logic [31:0] model [NUM_WORDS];   // expected bank contents
    logic [31:0] frames [$];
    int          sync_lows [$];
    int          frames_at_sync;
    int          errors = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    integer      seed;

    logic [31:0] frame_bits = '0;
    int          frame_len = 0;
    logic        in_frame = 1'b0;
    int          sync_len = 0;

    clk_synth_config DUT (
        .slow_clk (slow_clk),
        .resetS   (resetS),
        .wr       (wr),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .dclk     (dclk),
        .ddat     (ddat),
        .dlen     (dlen),
        .sync     (sync),
        .busy     (busy)
    );

    initial slow_clk = 1'b0;
    always #5 slow_clk = ~slow_clk;

    task automatic report_mismatch(input string msg);
        $display("error %0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("timeout at %0t: %s", $time, what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // ================================================
    // frame and sync monitor, on the rising edge of dclk
    // ================================================
    always @(posedge dclk) begin
        if (resetS !== 1'b0) begin
            in_frame  = 1'b0;   // drop a frame cut by reset
            frame_len = 0;
            sync_len  = 0;
        end else begin
            if (dlen === 1'b0) begin
                frame_bits = {frame_bits[30:0], ddat};
                frame_len++;
                in_frame = 1'b1;
            end else if (in_frame) begin
                assert (frame_len == 32)
                    else report_mismatch($sformatf("frame of %0d bits", frame_len));
                frames.push_back(frame_bits);
                in_frame  = 1'b0;
                frame_len = 0;
            end
            if (sync === 1'b0) begin
                if (sync_len == 0) frames_at_sync = frames.size();
                sync_len++;
            end else if (sync_len != 0) begin
                sync_lows.push_back(sync_len);
                sync_len = 0;
            end
        end
    end

    task automatic clear_capture;
        frames.delete();
        sync_lows.delete();
        frames_at_sync = -1;
    endtask

    task automatic model_write(input logic [`SYNTH_ADDR_W-1:0] addr, input logic [31:0] data);
        if (int'(addr) < NUM_WORDS) model[addr] = data;
    endtask

    task automatic wait_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            @(negedge slow_clk);
            n++;
        end
        if (busy !== level) timeout_fail(what);
    endtask

    task automatic wait_frames(input int count);
        int n;
        n = 0;
        while (frames.size() < count && n < FRAME_TIMEOUT) begin
            @(negedge slow_clk);
            n++;
        end
        if (frames.size() < count) timeout_fail("too few frames arrived before the reset");
    endtask

    // drive on the falling edge, transfer on the rising edge with ready high
    task automatic bus_write(input logic [`SYNTH_ADDR_W-1:0] addr, input logic [31:0] data,
                             output int waited);
        int n;
        @(negedge slow_clk);
        wr.addr  = addr;
        wr.data  = data;
        wr_valid = 1'b1;
        n = 0;
        while (wr_ready !== 1'b1 && n < SEQ_TIMEOUT) begin
            @(negedge slow_clk);
            n++;
        end
        if (wr_ready !== 1'b1) timeout_fail("wr_ready never rose for a pending write");
        waited = n;
        @(negedge slow_clk);
        wr_valid = 1'b0;
        wr       = '0;
    endtask

    task automatic apply_reset;
        @(negedge slow_clk);
        resetS = 1'b1;
        repeat (RESET_CYCLES) @(negedge slow_clk);
        assert (dlen === 1'b1 && sync === 1'b1 && ddat === 1'b0 && wr_ready === 1'b0 &&
                busy === 1'b1 && DUT.req_valid === 1'b0)
            else report_mismatch($sformatf("in reset dlen %b sync %b ddat %b wr_ready %b busy %b",
                                           dlen, sync, ddat, wr_ready, busy));
        resetS = 1'b0;
        clear_capture();
        for (int i = 0; i < NUM_WORDS; i++) begin
            model[i] = synth_prog_pkg::DEFAULT_WORDS[i];
        end
    endtask

    task automatic check_run_result;
        assert (frames.size() == NUM_WORDS)
            else report_mismatch($sformatf("%0d frames, expected %0d", frames.size(), NUM_WORDS));
        for (int i = 0; i < frames.size() && i < NUM_WORDS; i++) begin
            assert (frames[i] === model[i])
                else report_mismatch($sformatf("frame %0d is %h, expected %h",
                                               i, frames[i], model[i]));
        end
        assert (sync_lows.size() == 1 && frames_at_sync == NUM_WORDS)
            else report_mismatch($sformatf("%0d sync pulses, first after %0d frames",
                                           sync_lows.size(), frames_at_sync));
        if (sync_lows.size() > 0) begin
            assert (sync_lows[0] == `SYNTH_SYNC_LOW_CYCLES)
                else report_mismatch($sformatf("sync low for %0d cycles", sync_lows[0]));
        end
    endtask

    task automatic expect_run;
        wait_busy(1'b1, START_TIMEOUT, "busy did not rise for a sequence");
        wait_busy(1'b0, SEQ_TIMEOUT, "busy did not fall at the end of a sequence");
        check_run_result();
    endtask

    task automatic check_quiet;
        int noisy;
        noisy = 0;
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge slow_clk);
            if (dlen !== 1'b1 || busy !== 1'b0) noisy++;
        end
        assert (noisy == 0 && frames.size() == 0)
            else report_mismatch($sformatf("dlen or busy active in %0d quiet cycles", noisy));
    endtask

    task automatic run_entry(input stim_t e);
        int waited;
        clear_capture();
        case (e.op)
            OP_AUTO: apply_reset();
            OP_WRITE, OP_NO_RUN, OP_START: begin
                bus_write(e.addr, e.data, waited);
                model_write(e.addr, e.data);
            end
            OP_LATE_WRITE: begin
                bus_write(CTRL, 32'h1, waited);
                wait_busy(1'b1, START_TIMEOUT, "busy did not rise after a start");
                bus_write(e.addr, e.data, waited);   // held until busy falls
                assert (waited > 0 && busy === 1'b0)
                    else report_mismatch($sformatf("late write taken after %0d cycles", waited));
                check_run_result();   // running sequence still has the old word
                model_write(e.addr, e.data);
                clear_capture();
            end
            OP_RESET_MID: begin
                bus_write(CTRL, 32'h1, waited);
                wait_busy(1'b1, START_TIMEOUT, "busy did not rise after a start");
                wait_frames(4);
                apply_reset();
            end
            default: report_mismatch("unknown table entry");
        endcase
        if (e.runs) begin
            expect_run();
        end else begin
            check_quiet();
        end
    endtask

    task automatic add_entry(input int id, input op_t op, input int addr,
                             input logic [31:0] data, input logic runs);
        stim_t e;
        e.test_id = 4'(id);
        e.op      = op;
        e.addr    = `SYNTH_ADDR_W'(addr);
        e.data    = data;
        e.runs    = runs;
        table_q.push_back(e);
    endtask

    // ================================================
    // stimulus table
    // ================================================
    task automatic build_table;
        add_entry(1, OP_AUTO, 0, 32'h0, 1'b1);
        add_entry(2, OP_WRITE, 3, $random(seed), 1'b0);
        add_entry(2, OP_WRITE, 7, $random(seed), 1'b0);
        add_entry(2, OP_WRITE, 12, $random(seed), 1'b0);
        add_entry(2, OP_WRITE, 25, $random(seed), 1'b0);
        add_entry(2, OP_WRITE, 0, $random(seed), 1'b0);
        add_entry(2, OP_START, 26, 32'h1, 1'b1);
        add_entry(3, OP_LATE_WRITE, 5, $random(seed), 1'b0);
        add_entry(3, OP_START, 26, 32'h1, 1'b1);
        add_entry(4, OP_NO_RUN, 26, 32'hFFFF_FFFE, 1'b0);   // bit 0 clear
        add_entry(4, OP_NO_RUN, 27, 32'h1, 1'b0);
        add_entry(4, OP_NO_RUN, 31, $random(seed) | 32'h1, 1'b0);
        add_entry(4, OP_START, 26, 32'h1, 1'b1);
        add_entry(5, OP_WRITE, 9, $random(seed), 1'b0);
        add_entry(5, OP_WRITE, 20, $random(seed), 1'b0);
        add_entry(5, OP_RESET_MID, 26, 32'h1, 1'b1);
    endtask

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1: return "power-up defaults";
            4'd2: return "written words";
            4'd3: return "write held by busy";
            4'd4: return "ignored writes";
            4'd5: return "reset mid-sequence";
            default: return "unnamed";
        endcase
    endfunction

    task automatic finish_test(input logic [3:0] id);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", id, test_name(id));
        end else begin
            $display("test %0d %s: %0d errors", id, test_name(id), test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    initial begin
        seed     = 32'ha08b_3b59;
        resetS   = 1'b1;
        wr       = '0;
        wr_valid = 1'b0;
        clear_capture();
        build_table();
        for (int i = 0; i < table_q.size(); i++) begin
            run_entry(table_q[i]);
            if (i == table_q.size() - 1 || table_q[i + 1].test_id != table_q[i].test_id) begin
                finish_test(table_q[i].test_id);
            end
        end
        errors += DUT.u_props.fail_count;   // concurrent assertion failures
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, DUT.u_props.fail_count);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
